/* src/rv_core_defines.svh */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// datapath and register file geometry
`define RV_XLEN     32 // data and address width
`define RV_REG_AW   5  // register index width
`define RV_NUM_REGS 32 // x0 plus 31 writable registers

// the first fetch after reset comes from here
`define RV_RESET_ADDR 32'h0000_0000

// major opcodes the core recognizes, everything else traps
`define RV_OP_OP     7'b0110011 // register-register alu
`define RV_OP_OP_IMM 7'b0010011 // register-immediate alu
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_SYSTEM 7'b1110011 // only ebreak is kept

// funct3 selects the alu operation for both OP and OP_IMM
`define RV_F3_ADD_SUB 3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SRL_SRA 3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// funct7 values, the alternate one turns add into sub and srl into sra
`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000

`define RV_INST_EBREAK 32'h0010_0073 // halts the core when it reaches decode

`endif

/* src/rv_core_pkg.sv */
`include "rv_core_defines.svh"

package rv_core_pkg;

  // one data word, also used for addresses and instruction words
  typedef logic [`RV_XLEN-1:0] word_t;

  typedef logic [`RV_REG_AW-1:0] reg_addr_t; // index into the register file

  // operations the execute stage can perform
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b // operand b straight through, this is how lui gets its result
  } alu_op_t;

  // where operand a comes from
  typedef enum logic [1:0] {
    a_rs1,  // register rs1, possibly forwarded
    a_pc,   // pc of the instruction itself, for auipc
    a_zero  // constant zero
  } a_sel_t;

endpackage

/* src/rv_decoder.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_decoder (
  input  rv_core_pkg::word_t     i_inst,
  output rv_core_pkg::reg_addr_t o_rs1_addr,
  output rv_core_pkg::reg_addr_t o_rs2_addr,
  output rv_core_pkg::reg_addr_t o_rd_addr,
  output rv_core_pkg::word_t     o_imm,
  output rv_core_pkg::alu_op_t   o_alu_op,
  output rv_core_pkg::a_sel_t    o_a_sel,
  output logic                   o_b_imm,
  output logic                   o_illegal,
  output logic                   o_halt
);

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  rv_core_pkg::word_t     imm_i;    // sign extended bits 31:20
  rv_core_pkg::word_t     imm_u;    // upper 20 bits, low 12 zero
  logic                   alt;      // bit 30 picks sub or sra where it matters
  logic                   f7_ok;    // funct7 is legal for this funct3
  rv_core_pkg::alu_op_t   f3_op;    // alu operation implied by funct3

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign imm_i  = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u  = {i_inst[31:12], 12'b0};

  // for immediates only the shift right uses bit 30, addi with bit 30 set stays an add
  assign alt = i_inst[30] & ((opcode == `RV_OP_OP) | (funct3 == `RV_F3_SRL_SRA));

  // register forms need a clean funct7, immediate forms only check it on shifts
  always_comb begin
    if (opcode == `RV_OP_OP || funct3 == `RV_F3_SLL || funct3 == `RV_F3_SRL_SRA) begin
      f7_ok = (funct7 == `RV_F7_BASE) |
              ((funct7 == `RV_F7_ALT) & (funct3 == `RV_F3_SRL_SRA)) |
              ((funct7 == `RV_F7_ALT) & (funct3 == `RV_F3_ADD_SUB) & (opcode == `RV_OP_OP));
    end else begin
      f7_ok = 1'b1; // the upper bits are just immediate here
    end
  end

  always_comb begin
    case (funct3)
      `RV_F3_ADD_SUB: f3_op = alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
      `RV_F3_SLL:     f3_op = rv_core_pkg::alu_sll;
      `RV_F3_SLT:     f3_op = rv_core_pkg::alu_slt;
      `RV_F3_SLTU:    f3_op = rv_core_pkg::alu_sltu;
      `RV_F3_XOR:     f3_op = rv_core_pkg::alu_xor;
      `RV_F3_SRL_SRA: f3_op = alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
      `RV_F3_OR:      f3_op = rv_core_pkg::alu_or;
      default:        f3_op = rv_core_pkg::alu_and;
    endcase
  end

  always_comb begin
    // defaults describe an instruction that reads and writes nothing
    o_rs1_addr = '0;
    o_rs2_addr = '0;
    o_rd_addr  = '0;
    o_imm      = imm_i;
    o_alu_op   = rv_core_pkg::alu_add;
    o_a_sel    = rv_core_pkg::a_rs1;
    o_b_imm    = 1'b0;
    o_illegal  = 1'b0;
    o_halt     = 1'b0;
    case (opcode)
      `RV_OP_OP: begin
        o_illegal = ~f7_ok;
        if (f7_ok) begin
          o_rs1_addr = i_inst[19:15];
          o_rs2_addr = i_inst[24:20];
          o_rd_addr  = i_inst[11:7];
          o_alu_op   = f3_op;
        end
      end
      `RV_OP_OP_IMM: begin
        o_illegal = ~f7_ok;
        o_b_imm   = 1'b1;
        if (f7_ok) begin
          o_rs1_addr = i_inst[19:15];
          o_rd_addr  = i_inst[11:7];
          o_alu_op   = f3_op; // shifts only look at the low five bits of imm
        end
      end
      `RV_OP_LUI: begin
        o_rd_addr = i_inst[11:7];
        o_imm     = imm_u;
        o_alu_op  = rv_core_pkg::alu_pass_b;
        o_a_sel   = rv_core_pkg::a_zero;
        o_b_imm   = 1'b1;
      end
      `RV_OP_AUIPC: begin
        o_rd_addr = i_inst[11:7];
        o_imm     = imm_u;
        o_a_sel   = rv_core_pkg::a_pc; // pc plus upper immediate
        o_b_imm   = 1'b1;
      end
      `RV_OP_SYSTEM: begin
        o_halt    = (i_inst == `RV_INST_EBREAK);
        o_illegal = (i_inst != `RV_INST_EBREAK); // ecall and csr access trap
      end
      default: o_illegal = 1'b1;
    endcase
  end

endmodule

/* src/rv_regfile.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_regfile (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  rv_core_pkg::reg_addr_t i_rs1_addr,
  input  rv_core_pkg::reg_addr_t i_rs2_addr,
  output rv_core_pkg::word_t     o_rs1_data,
  output rv_core_pkg::word_t     o_rs2_data,
  input  logic                   i_rd_wen,
  input  rv_core_pkg::reg_addr_t i_rd_addr,
  input  rv_core_pkg::word_t     i_rd_wdata
);

  // x0 has no storage, only x1 and up are real flops
  rv_core_pkg::word_t regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0; // every register starts out as zero
      end
    end else if (i_rd_wen && i_rd_addr != '0) begin
      regs[i_rd_addr] <= i_rd_wdata; // writes aimed at x0 fall away here
    end
  end

  // reads are combinational so decode sees the value in the same cycle
  // a write lands at the clock edge and shows up on the next read
  always_comb begin
    o_rs1_data = '0;
    o_rs2_data = '0;
    if (i_rs1_addr != '0) begin
      o_rs1_data = regs[i_rs1_addr];
    end
    if (i_rs2_addr != '0) begin
      o_rs2_data = regs[i_rs2_addr];
    end
  end

endmodule

/* src/rv_execute.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_execute (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_valid,
  input  rv_core_pkg::word_t     i_inst,
  input  rv_core_pkg::word_t     i_pc,
  input  rv_core_pkg::reg_addr_t i_rs1_addr,
  input  rv_core_pkg::reg_addr_t i_rs2_addr,
  input  rv_core_pkg::reg_addr_t i_rd_addr,
  input  rv_core_pkg::word_t     i_rs1_data,
  input  rv_core_pkg::word_t     i_rs2_data,
  input  rv_core_pkg::word_t     i_imm,
  input  rv_core_pkg::alu_op_t   i_alu_op,
  input  rv_core_pkg::a_sel_t    i_a_sel,
  input  logic                   i_b_imm,
  input  logic                   i_illegal,
  input  logic                   i_halt,
  output logic                   o_rd_wen,
  output rv_core_pkg::reg_addr_t o_rd_addr,
  output rv_core_pkg::word_t     o_rd_wdata,
  output logic                   o_retire_valid,
  output logic                   o_retire_trap,
  output logic                   o_retire_halt,
  output rv_core_pkg::word_t     o_retire_inst,
  output rv_core_pkg::word_t     o_retire_pc,
  output rv_core_pkg::word_t     o_retire_rd_wdata,
  output rv_core_pkg::reg_addr_t o_retire_rd_waddr
);

  // decode to execute register
  logic                   ex_valid_q;
  logic                   ex_illegal_q;
  logic                   ex_halt_q;
  rv_core_pkg::word_t     ex_inst_q;
  rv_core_pkg::word_t     ex_pc_q;
  rv_core_pkg::reg_addr_t ex_rs1_addr_q;
  rv_core_pkg::reg_addr_t ex_rs2_addr_q;
  rv_core_pkg::reg_addr_t ex_rd_addr_q;
  rv_core_pkg::word_t     ex_rs1_data_q;
  rv_core_pkg::word_t     ex_rs2_data_q;
  rv_core_pkg::word_t     ex_imm_q;
  rv_core_pkg::alu_op_t   ex_alu_op_q;
  rv_core_pkg::a_sel_t    ex_a_sel_q;
  logic                   ex_b_imm_q;

  logic                   fwd_rs1;   // rs1 was written by the instruction that just retired
  logic                   fwd_rs2;
  rv_core_pkg::word_t     rs1_val;
  rv_core_pkg::word_t     rs2_val;
  rv_core_pkg::word_t     op_a;
  rv_core_pkg::word_t     op_b;
  logic [4:0]             shamt;
  rv_core_pkg::word_t     result;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ex_valid_q   <= 1'b0;
      ex_illegal_q <= 1'b0;
      ex_halt_q    <= 1'b0;
    end else begin
      ex_valid_q   <= i_valid;
      ex_illegal_q <= i_illegal;
      ex_halt_q    <= i_halt;
    end
  end

  // payload follows along every cycle, only the valid bit gives it meaning
  always_ff @(posedge i_clk) begin
    ex_inst_q     <= i_inst;
    ex_pc_q       <= i_pc;
    ex_rs1_addr_q <= i_rs1_addr;
    ex_rs2_addr_q <= i_rs2_addr;
    ex_rd_addr_q  <= i_rd_addr;
    ex_rs1_data_q <= i_rs1_data;
    ex_rs2_data_q <= i_rs2_data;
    ex_imm_q      <= i_imm;
    ex_alu_op_q   <= i_alu_op;
    ex_a_sel_q    <= i_a_sel;
    ex_b_imm_q    <= i_b_imm;
  end

  // the regfile read in decode happened one edge before the previous write landed
  // so only the instruction directly ahead can be missing from it
  assign fwd_rs1 = o_retire_valid & (o_retire_rd_waddr != '0) &
                   (o_retire_rd_waddr == ex_rs1_addr_q);
  assign fwd_rs2 = o_retire_valid & (o_retire_rd_waddr != '0) &
                   (o_retire_rd_waddr == ex_rs2_addr_q);
  assign rs1_val = fwd_rs1 ? o_retire_rd_wdata : ex_rs1_data_q;
  assign rs2_val = fwd_rs2 ? o_retire_rd_wdata : ex_rs2_data_q;

  always_comb begin
    case (ex_a_sel_q)
      rv_core_pkg::a_pc:   op_a = ex_pc_q;
      rv_core_pkg::a_zero: op_a = '0;
      default:             op_a = rv_core_pkg::word_t'(rs1_val);
    endcase
  end

  assign op_b  = ex_b_imm_q ? ex_imm_q : rs2_val;
  assign shamt = op_b[4:0]; // shifts use only five bits of the amount

  always_comb begin
    case (ex_alu_op_q)
      rv_core_pkg::alu_add:    result = op_a + op_b;
      rv_core_pkg::alu_sub:    result = op_a - op_b;
      rv_core_pkg::alu_and:    result = op_a & op_b;
      rv_core_pkg::alu_or:     result = op_a | op_b;
      rv_core_pkg::alu_xor:    result = op_a ^ op_b;
      rv_core_pkg::alu_sll:    result = op_a << shamt;
      rv_core_pkg::alu_srl:    result = op_a >> shamt;
      rv_core_pkg::alu_sra:    result = $signed(op_a) >>> shamt;
      rv_core_pkg::alu_slt:    result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_core_pkg::alu_sltu:   result = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      default:                 result = op_b; // pass_b for lui
    endcase
  end

  // illegal words and ebreak carry rd 0 from the decoder, so valid alone gates the write
  assign o_rd_wen   = ex_valid_q;
  assign o_rd_addr  = ex_rd_addr_q;
  assign o_rd_wdata = result;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_retire_valid <= 1'b0;
      o_retire_trap  <= 1'b0;
      o_retire_halt  <= 1'b0;
    end else begin
      o_retire_valid <= ex_valid_q;
      o_retire_trap  <= ex_valid_q & ex_illegal_q;
      o_retire_halt  <= ex_valid_q & ex_halt_q;
    end
  end

  always_ff @(posedge i_clk) begin
    o_retire_inst     <= ex_inst_q;
    o_retire_pc       <= ex_pc_q;
    o_retire_rd_waddr <= ex_rd_addr_q;
    o_retire_rd_wdata <= result; // also the forwarding source for the next instruction
  end

endmodule

/* src/rv_core.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module rv_core (
  input  logic                   i_clk,
  input  logic                   i_rst,
  output rv_core_pkg::word_t     o_imem_raddr,
  input  rv_core_pkg::word_t     i_imem_rdata,
  output logic                   o_retire_valid,
  output logic                   o_retire_trap,
  output logic                   o_retire_halt,
  output rv_core_pkg::word_t     o_retire_inst,
  output rv_core_pkg::word_t     o_retire_pc,
  output rv_core_pkg::word_t     o_retire_rd_wdata,
  output rv_core_pkg::reg_addr_t o_retire_rd_waddr
);

  rv_core_pkg::word_t     pc_q;           // address being fetched this cycle
  logic                   fetch_valid_q;  // the word on i_imem_rdata is a real fetch
  logic                   halted_q;
  rv_core_pkg::word_t     fd_pc_q;        // pc of the word now in decode
  logic                   halt_hit;
  logic                   fetch_en;

  rv_core_pkg::reg_addr_t dec_rs1_addr;
  rv_core_pkg::reg_addr_t dec_rs2_addr;
  rv_core_pkg::reg_addr_t dec_rd_addr;
  rv_core_pkg::word_t     dec_imm;
  rv_core_pkg::alu_op_t   dec_alu_op;
  rv_core_pkg::a_sel_t    dec_a_sel;
  logic                   dec_b_imm;
  logic                   dec_illegal;
  logic                   dec_halt;
  rv_core_pkg::word_t     rf_rs1_data;
  rv_core_pkg::word_t     rf_rs2_data;
  logic                   rf_wen;
  rv_core_pkg::reg_addr_t rf_waddr;
  rv_core_pkg::word_t     rf_wdata;

  // ebreak in decode stops fetch, the word behind it is dropped by clearing fetch_valid_q
  assign halt_hit = fetch_valid_q & dec_halt;
  assign fetch_en = ~halted_q & ~halt_hit;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q          <= `RV_RESET_ADDR;
      fetch_valid_q <= 1'b0;
      halted_q      <= 1'b0;
    end else begin
      fetch_valid_q <= fetch_en;
      if (halt_hit) begin
        halted_q <= 1'b1; // only reset brings the core back
      end
      if (fetch_en) begin
        pc_q <= pc_q + rv_core_pkg::word_t'(4);
      end
    end
  end

  // the memory registers the word itself, the pc has to be carried alongside it
  always_ff @(posedge i_clk) begin
    fd_pc_q <= pc_q;
  end

  assign o_imem_raddr = pc_q;

  rv_decoder decoder_inst (
    .i_inst     (i_imem_rdata),
    .o_rs1_addr (dec_rs1_addr),
    .o_rs2_addr (dec_rs2_addr),
    .o_rd_addr  (dec_rd_addr),
    .o_imm      (dec_imm),
    .o_alu_op   (dec_alu_op),
    .o_a_sel    (dec_a_sel),
    .o_b_imm    (dec_b_imm),
    .o_illegal  (dec_illegal),
    .o_halt     (dec_halt)
  );

  // register read happens beside the decoder on the same instruction
  rv_regfile regfile_inst (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1_addr (dec_rs1_addr),
    .i_rs2_addr (dec_rs2_addr),
    .o_rs1_data (rf_rs1_data),
    .o_rs2_data (rf_rs2_data),
    .i_rd_wen   (rf_wen),
    .i_rd_addr  (rf_waddr),
    .i_rd_wdata (rf_wdata)
  );

  rv_execute execute_inst (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_valid           (fetch_valid_q),
    .i_inst            (i_imem_rdata),
    .i_pc              (fd_pc_q),
    .i_rs1_addr        (dec_rs1_addr),
    .i_rs2_addr        (dec_rs2_addr),
    .i_rd_addr         (dec_rd_addr),
    .i_rs1_data        (rf_rs1_data),
    .i_rs2_data        (rf_rs2_data),
    .i_imm             (dec_imm),
    .i_alu_op          (dec_alu_op),
    .i_a_sel           (dec_a_sel),
    .i_b_imm           (dec_b_imm),
    .i_illegal         (dec_illegal),
    .i_halt            (dec_halt),
    .o_rd_wen          (rf_wen),
    .o_rd_addr         (rf_waddr),
    .o_rd_wdata        (rf_wdata),
    .o_retire_valid    (o_retire_valid),
    .o_retire_trap     (o_retire_trap),
    .o_retire_halt     (o_retire_halt),
    .o_retire_inst     (o_retire_inst),
    .o_retire_pc       (o_retire_pc),
    .o_retire_rd_wdata (o_retire_rd_wdata),
    .o_retire_rd_waddr (o_retire_rd_waddr)
  );

endmodule

/* test/tb_rv_ref.svh */
`ifndef TB_RV_REF_SVH
`define TB_RV_REF_SVH

// one step of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] next_rand();
  rng_state = xorshift32(rng_state); // the shared state lives in the testbench top
  return rng_state;
endfunction

// draws one instruction, half the time a source reuses the previous destination
function automatic rv_core_pkg::word_t random_inst(input rv_core_pkg::reg_addr_t prev_rd);
  logic [31:0] r;
  logic [31:0] s;
  logic [3:0]  kind;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [11:0] imm;
  r    = next_rand();
  s    = next_rand();
  kind = r[28:25];
  f3   = s[2:0];
  f7   = ((f3 == `RV_F3_ADD_SUB || f3 == `RV_F3_SRL_SRA) && s[3]) ? `RV_F7_ALT : `RV_F7_BASE;
  rd   = (r[7:5] == 3'd0) ? 5'd0 : r[12:8]; // x0 as destination about one time in eight
  rs1  = r[13] ? prev_rd : r[18:14];
  rs2  = r[19] ? prev_rd : r[24:20];
  if (f3 == `RV_F3_SLL) begin
    imm = {`RV_F7_BASE, s[24:20]};
  end else if (f3 == `RV_F3_SRL_SRA) begin
    imm = {f7, s[24:20]}; // srli or srai
  end else begin
    imm = s[31:20];
  end
  if (kind <= 4'd5 || kind == 4'd15) begin
    return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
  end else if (kind <= 4'd10) begin
    return {imm, rs1, f3, rd, `RV_OP_OP_IMM};
  end else if (kind == 4'd11) begin
    return {s[31:12], rd, `RV_OP_LUI};
  end else if (kind == 4'd12) begin
    return {s[31:12], rd, `RV_OP_AUIPC};
  end else if (kind == 4'd13) begin
    return {7'b0000001, rs2, rs1, f3, rd, `RV_OP_OP}; // multiply group, not in this core
  end
  // ecall or a load opcode, both trap here
  return s[4] ? 32'h0000_0073 : {s[31:7], 7'b0000011};
endfunction

// integer operation picked by funct3, alt marks sub and sra
function automatic rv_core_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                             input rv_core_pkg::word_t a,
                                             input rv_core_pkg::word_t b);
  logic signed [31:0] sa;
  sa = a;
  case (f3)
    `RV_F3_ADD_SUB: return alt ? a - b : a + b;
    `RV_F3_SLL:     return a << b[4:0];
    `RV_F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    `RV_F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
    `RV_F3_XOR:     return a ^ b;
    `RV_F3_SRL_SRA: begin
      if (alt) begin
        sa = sa >>> b[4:0]; // arithmetic shift keeps the sign bit
        return sa;
      end
      return a >> b[4:0];
    end
    `RV_F3_OR:      return a | b;
    default:        return a & b;
  endcase
endfunction

// executes one instruction on the software register file in program order
function automatic void ref_step(input rv_core_pkg::word_t inst, input rv_core_pkg::word_t pc,
                                 output rv_core_pkg::reg_addr_t rd,
                                 output rv_core_pkg::word_t wdata,
                                 output logic trap, output logic halt);
  logic [6:0]         opc;
  logic [2:0]         f3;
  logic [6:0]         f7;
  rv_core_pkg::word_t a;
  rv_core_pkg::word_t imm_i;
  rv_core_pkg::word_t imm_u;
  opc   = inst[6:0];
  f3    = inst[14:12];
  f7    = inst[31:25];
  a     = ref_regs[inst[19:15]]; // entry 0 is never written so x0 reads zero
  imm_i = {{20{inst[31]}}, inst[31:20]};
  imm_u = {inst[31:12], 12'h000};
  rd    = inst[11:7];
  wdata = '0;
  trap  = 1'b0;
  halt  = 1'b0;
  case (opc)
    `RV_OP_OP: begin
      if (f7 == `RV_F7_BASE ||
          (f7 == `RV_F7_ALT && (f3 == `RV_F3_ADD_SUB || f3 == `RV_F3_SRL_SRA))) begin
        wdata = alu_ref(f3, f7[5], a, ref_regs[inst[24:20]]);
      end else begin
        trap = 1'b1;
      end
    end
    `RV_OP_OP_IMM: begin
      if (f3 == `RV_F3_SLL && f7 != `RV_F7_BASE) begin
        trap = 1'b1;
      end else if (f3 == `RV_F3_SRL_SRA && f7 != `RV_F7_BASE && f7 != `RV_F7_ALT) begin
        trap = 1'b1;
      end else begin
        wdata = alu_ref(f3, (f3 == `RV_F3_SRL_SRA) && (f7 == `RV_F7_ALT), a, imm_i);
      end
    end
    `RV_OP_LUI:    wdata = imm_u;
    `RV_OP_AUIPC:  wdata = pc + imm_u;
    `RV_OP_SYSTEM: begin
      halt = (inst == `RV_INST_EBREAK);
      trap = (inst != `RV_INST_EBREAK);
    end
    default:       trap = 1'b1;
  endcase
  if (trap || halt) begin
    rd = '0; // neither writes a register
  end
  if (rd != '0) begin
    ref_regs[rd] = wdata;
  end
endfunction

`endif

/* test/tb_rv_core.sv */
`timescale 1ns/100ps
`include "rv_core_defines.svh"

module tb_rv_core;

  localparam int RST_CYCLES     = 16;
  localparam int PROG_LEN       = 200; // the last word is ebreak
  localparam int LATENCY        = 3;   // address on o_imem_raddr to retire
  localparam int MARGIN         = 20;
  localparam int QUIET_CYCLES   = 10;  // watched after the halt for a stray retire
  localparam int TIMEOUT_CYCLES = RST_CYCLES + PROG_LEN + LATENCY + MARGIN;

  logic                   i_clk = 1'b0;
  logic                   i_rst;
  rv_core_pkg::word_t     o_imem_raddr;
  rv_core_pkg::word_t     i_imem_rdata;
  logic                   o_retire_valid;
  logic                   o_retire_trap;
  logic                   o_retire_halt;
  rv_core_pkg::word_t     o_retire_inst;
  rv_core_pkg::word_t     o_retire_pc;
  rv_core_pkg::word_t     o_retire_rd_wdata;
  rv_core_pkg::reg_addr_t o_retire_rd_waddr;

  rv_core_pkg::word_t     program_mem [0:PROG_LEN-1];
  rv_core_pkg::word_t     ref_regs [0:`RV_NUM_REGS-1]; // software register file
  logic [31:0]            rng_state;
  int                     cycle_count = 0;

  `include "tb_rv_ref.svh"

  rv_core rv_core_inst (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .o_imem_raddr      (o_imem_raddr),
    .i_imem_rdata      (i_imem_rdata),
    .o_retire_valid    (o_retire_valid),
    .o_retire_trap     (o_retire_trap),
    .o_retire_halt     (o_retire_halt),
    .o_retire_inst     (o_retire_inst),
    .o_retire_pc       (o_retire_pc),
    .o_retire_rd_wdata (o_retire_rd_wdata),
    .o_retire_rd_waddr (o_retire_rd_waddr)
  );

  always #50 i_clk = ~i_clk; // 100 ns period

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input string name, input rv_core_pkg::word_t exp,
                            input rv_core_pkg::word_t act);
    if (act !== exp) begin
      $display("error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_reg_addr(input string name, input rv_core_pkg::reg_addr_t exp,
                                input rv_core_pkg::reg_addr_t act);
    if (act !== exp) begin
      $display("error at %0d ns: %s expected x%0d, got x%0d", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error at %0d ns: %s expected %b, got %b", $time, name, exp, act);
      stop_with_failure();
    end
  endtask

  // returns the program below PROG_LEN and an address dependent filler above it
  function automatic rv_core_pkg::word_t mem_word(input rv_core_pkg::word_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < PROG_LEN) begin
      return program_mem[idx];
    end
    return {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
  endfunction

  initial begin : stimulus
    rv_core_pkg::reg_addr_t prev_rd;
    i_rst     = 1'b1;
    rng_state = 32'h843a5fcd;
    prev_rd   = '0;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      program_mem[i] = random_inst(prev_rd);
      prev_rd        = program_mem[i][11:7]; // the next word may depend on this one
    end
    program_mem[PROG_LEN-1] = `RV_INST_EBREAK;
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      ref_regs[i] = '0; // matches the cleared register file after reset
    end
    repeat (RST_CYCLES) @(negedge i_clk);
    i_rst = 1'b0;
  end

  // the address seen at one falling edge is answered at the next one like a synchronous read
  initial begin : imem_model
    rv_core_pkg::word_t fetch_addr;
    i_imem_rdata = '0;
    fetch_addr   = `RV_RESET_ADDR;
    forever begin
      @(negedge i_clk);
      i_imem_rdata = mem_word(fetch_addr);
      fetch_addr   = o_imem_raddr;
    end
  end

  // retire number j must appear LATENCY plus j cycles after reset and in program order
  initial begin : retire_checker
    int                     retired;
    logic                   exp_valid;
    logic                   exp_trap;
    logic                   exp_halt;
    rv_core_pkg::word_t     exp_pc;
    rv_core_pkg::word_t     exp_inst;
    rv_core_pkg::word_t     exp_wdata;
    rv_core_pkg::reg_addr_t exp_rd;
    rv_core_pkg::word_t     exp_raddr;
    rv_core_pkg::word_t     stop_addr;
    retired   = 0;
    exp_pc    = `RV_RESET_ADDR;
    exp_raddr = `RV_RESET_ADDR;
    stop_addr = `RV_RESET_ADDR + 32'(4 * PROG_LEN); // one word past ebreak
    for (int k = 1; k < RST_CYCLES + LATENCY + PROG_LEN + QUIET_CYCLES; k++) begin
      @(negedge i_clk); // outputs move on the rising edge and are stable here
      // the pc steps once per edge after reset and freezes when ebreak reaches decode
      if (k > RST_CYCLES && exp_raddr != stop_addr) begin
        exp_raddr = exp_raddr + 32'd4;
      end
      check_word("o_imem_raddr", exp_raddr, o_imem_raddr);
      exp_valid = (k >= RST_CYCLES + LATENCY) && (retired < PROG_LEN);
      check_bit("o_retire_valid", exp_valid, o_retire_valid);
      if (exp_valid) begin
        exp_inst = mem_word(exp_pc);
        ref_step(exp_inst, exp_pc, exp_rd, exp_wdata, exp_trap, exp_halt);
        check_word("o_retire_pc", exp_pc, o_retire_pc);
        check_word("o_retire_inst", exp_inst, o_retire_inst);
        check_bit("o_retire_trap", exp_trap, o_retire_trap);
        check_bit("o_retire_halt", exp_halt, o_retire_halt);
        check_reg_addr("o_retire_rd_waddr", exp_rd, o_retire_rd_waddr);
        if (!exp_trap && !exp_halt) begin
          check_word("o_retire_rd_wdata", exp_wdata, o_retire_rd_wdata);
        end
        exp_pc  = exp_pc + 32'd4;
        retired = retired + 1;
      end else begin
        check_bit("o_retire_trap", 1'b0, o_retire_trap);
        check_bit("o_retire_halt", 1'b0, o_retire_halt);
      end
    end
    if (retired == PROG_LEN) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("only %0d of %0d instructions retired", retired, PROG_LEN);
      stop_with_failure();
    end
  end

  always @(posedge i_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

endmodule

/* rv_core.f */
+incdir+src
+incdir+test
src/rv_core_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_core.sv
test/tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the rv_core testbench with verilator, runs it and checks the log

set -u

# everything is relative to the project root, where this script lives
cd "$(dirname "$0")" || exit 1

build_dir=build
obj_dir=$build_dir/obj_dir
log_file=$build_dir/sim.log
pass_line='*** TEST PASSED ***'

if ! mkdir -p "$build_dir"; then
  echo "could not create $build_dir"
  exit 1
fi

# delays in the testbench need the timing engine
if ! verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    -f rv_core.f --top-module tb_rv_core -Mdir "$obj_dir" -o Vtb_rv_core; then
  echo "verilator build failed"
  exit 1
fi

# a fatal error in the testbench gives a nonzero status
if ! "$obj_dir/Vtb_rv_core" > "$log_file" 2>&1; then
  cat "$log_file"
  echo "simulation ended with an error, see $log_file"
  exit 1
fi

cat "$log_file"

if grep -q -F "$pass_line" "$log_file"; then
  echo "simulation passed"
  exit 0
else
  echo "pass line not found in $log_file"
  exit 1
fi
